// ==== hw/pixel_palette_mixer.sv ====
// streams one buffered line through the palette PROMs to 12-bit RGB at half clock rate
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module pixel_palette_mixer (
	input  logic                   clk_10M,
	input  logic                   RESET,
	input  logic                   line_start,
	output logic                   streaming,
	prom_write_if.mixer            prom,
	line_buf_if.mixer              lb,
	output logic [3*`CODE_W-1:0]   rgb,
	output logic                   rgb_valid
);
	import sprite_video_pkg::*;

	// index 0 is palette hi, 1 is palette lo
	logic [`WB_DW-1:0]   pal_mem [2][`PROM_DEPTH];
	logic [`PROM_AW-1:0] pal_addr;
	logic [`WB_DW-1:0]   hi;
	logic [`WB_DW-1:0]   lo;
	logic                phase;
	x_t                  pix_x;
	logic                rd_valid;

	function automatic code_t level_nibble(input logic [3:0] idx);
		level_nibble = level_table[idx][7:4];
	endfunction

	always_ff @(posedge clk_10M) begin
		if (prom.we && prom.id != color_lut) begin
			pal_mem[prom.id == pal_lo][prom.index] <= prom.data;
		end
	end

	assign pal_addr = {1'b0, lb.rd_code};
	assign hi = pal_mem[0][pal_addr];
	assign lo = pal_mem[1][pal_addr];

	// one read every other clock
	assign lb.rd_en = streaming && !phase;
	assign lb.rd_x = pix_x;

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			streaming <= 1'b0;
			phase <= 1'b0;
			pix_x <= '0;
			rd_valid <= 1'b0;
			rgb_valid <= 1'b0;
			rgb <= '0;
		end else begin
			if (!streaming) begin
				if (line_start) begin
					streaming <= 1'b1;
					phase <= 1'b0;
					pix_x <= '0;
				end
			end else begin
				phase <= ~phase;
				if (!phase) begin
					pix_x <= pix_x + 1'b1;
					if (pix_x == x_t'(`LINE_PIXELS-1)) begin
						streaming <= 1'b0;
					end
				end
			end
			rd_valid <= lb.rd_en;
			rgb_valid <= rd_valid;
			// code 0 shows black
			if (rd_valid && lb.rd_code != '0) begin
				rgb <= {level_nibble({hi[1:0], lo[1:0]}),
					level_nibble({hi[3:2], lo[3:2]}),
					level_nibble({hi[5:4], lo[5:4]})};
			end else begin
				rgb <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_blitter.sv ====
// expands one 8-pixel sprite row through the color lookup PROM into the line buffer
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_blitter (
	input  logic                           clk_10M,
	input  logic                           RESET,
	prom_write_if.blitter                  prom,
	line_buf_if.blitter                    lb,
	input  logic                           start,
	input  sprite_video_pkg::x_t           sprite_x,
	input  sprite_video_pkg::sprite_color_t sprite_color,
	input  logic [`ROW_PIXELS-1:0]         plane0,
	input  logic [`ROW_PIXELS-1:0]         plane1,
	output logic                           busy
);
	import sprite_video_pkg::*;

	localparam int step_w = $clog2(`ROW_PIXELS);

	logic [`WB_DW-1:0]      lut [`PROM_DEPTH];
	x_t                     x_q;
	sprite_color_t          color_q;
	logic [`ROW_PIXELS-1:0] p0_in;
	logic [`ROW_PIXELS-1:0] p1_in;
	logic [`ROW_PIXELS-1:0] p0_q;
	logic [`ROW_PIXELS-1:0] p1_q;
	logic [step_w-1:0]      step;
	logic [1:0]             pix;
	logic [`WB_DW-1:0]      lut_data;

	// color lookup PROM, loaded by the host
	always_ff @(posedge clk_10M) begin
		if (prom.we && prom.id == color_lut) begin
			lut[prom.index] <= prom.data;
		end
	end

	// x flip reverses the planes once at load, the shifter is the same after that
	always_comb begin
		for (int i = 0; i < `ROW_PIXELS; i++) begin
			p0_in[i] = sprite_color.flip_x ? plane0[`ROW_PIXELS-1-i] : plane0[i];
			p1_in[i] = sprite_color.flip_x ? plane1[`ROW_PIXELS-1-i] : plane1[i];
		end
	end

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			busy <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 1'b1;
			if (step == step_w'(`ROW_PIXELS-1)) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_10M) begin
		if (start) begin
			x_q <= sprite_x;
			color_q <= sprite_color;
			p0_q <= p0_in;
			p1_q <= p1_in;
		end else if (busy) begin
			p0_q <= p0_q >> 1;
			p1_q <= p1_q >> 1;
		end
	end

	assign pix = {p1_q[0], p0_q[0]};
	assign lut_data = lut[{color_q.group, pix}];

	// pixel value 0 is transparent, no write
	assign lb.wr_en = busy && pix != 2'b00;
	assign lb.wr_x = x_q + x_t'(step);
	assign lb.wr_code = color_q.nibble_sel ? lut_data[2*`CODE_W-1:`CODE_W]
		: lut_data[`CODE_W-1:0];

endmodule

`default_nettype wire

// ==== hw/sprite_host_port.sv ====
// Wishbone classic slave holding the sprite descriptor and routing PROM loads
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_host_port (
	input  logic                           clk_10M,
	input  logic                           RESET,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [`WB_AW-1:0]              wb_adr,
	input  logic [`WB_DW-1:0]              wb_dat_w,
	output logic [`WB_DW-1:0]              wb_dat_r,
	output logic                           wb_ack,
	prom_write_if.host                     prom,
	output logic                           start,
	output sprite_video_pkg::x_t           sprite_x,
	output sprite_video_pkg::sprite_color_t sprite_color,
	output logic [`ROW_PIXELS-1:0]         plane0,
	output logic [`ROW_PIXELS-1:0]         plane1,
	input  logic                           busy
);
	import sprite_video_pkg::*;

	wb_addr_u          adr;
	logic              req;
	logic              desc_sel;
	logic              prom_sel;
	logic              go_wr;
	logic              stall;
	logic [`WB_DW-1:0] rd_data;

	assign adr = wb_adr;
	// a cycle is taken once, the ack cycle itself is not a new request
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign desc_sel = adr.desc.region == region_desc;
	assign prom_sel = adr.prom.region == region_lut || adr.prom.region == region_pal;
	assign go_wr = req && wb_we && desc_sel && adr.desc.field == field_go;
	// go waits here until the blitter is free
	assign stall = go_wr && busy;

	always_comb begin
		rd_data = '0;
		if (desc_sel) begin
			case (adr.desc.field)
				field_x:      rd_data = sprite_x;
				field_color:  rd_data = sprite_color;
				field_plane0: rd_data = plane0;
				field_plane1: rd_data = plane1;
				field_go:     rd_data = {{(`WB_DW-1){1'b0}}, busy};
				default:      rd_data = '0;
			endcase
		end
	end

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			prom.we <= 1'b0;
		end else begin
			wb_ack <= req && !stall;
			start <= go_wr && !busy;
			prom.we <= req && wb_we && prom_sel;
		end
	end

	// descriptor, read data and PROM payload
	always_ff @(posedge clk_10M) begin
		prom.index <= adr.prom.index;
		prom.data <= wb_dat_w;
		if (adr.prom.region == region_lut) begin
			prom.id <= color_lut;
		end else begin
			prom.id <= adr.prom.table_sel ? pal_lo : pal_hi;
		end
		if (req && wb_we && desc_sel) begin
			case (adr.desc.field)
				field_x:      sprite_x <= wb_dat_w;
				field_color:  sprite_color <= wb_dat_w;
				field_plane0: plane0 <= wb_dat_w;
				field_plane1: plane1 <= wb_dat_w;
				default:      ;
			endcase
		end
		if (req) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_line_buffer.sv ====
// double line buffer, one half written by the blitter while the other is streamed out
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_line_buffer (
	input  logic         clk_10M,
	input  logic         RESET,
	input  logic         line_start,
	input  logic         streaming,
	line_buf_if.buffer   lb
);
	import sprite_video_pkg::*;

	code_t mem [2][`LINE_PIXELS];
	logic  bank;
	logic  rd_bank;
	logic  sweeping;
	x_t    sweep_x;

	// bank is the write half
	assign rd_bank = ~bank;

	always_ff @(posedge clk_10M) begin
		if (RESET) begin
			bank <= 1'b0;
			sweeping <= 1'b1;
			sweep_x <= '0;
		end else begin
			if (line_start && !streaming) begin
				bank <= ~bank;
			end
			if (sweeping) begin
				sweep_x <= sweep_x + 1'b1;
				if (sweep_x == x_t'(`LINE_PIXELS-1)) begin
					sweeping <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_10M) begin
		// power-up clear of both halves
		if (sweeping) begin
			mem[0][sweep_x] <= '0;
			mem[1][sweep_x] <= '0;
		end
		// read then clear, ready for the next fill
		if (lb.rd_en) begin
			lb.rd_code <= mem[rd_bank][lb.rd_x];
			mem[rd_bank][lb.rd_x] <= '0;
		end
		if (lb.wr_en) begin
			mem[bank][lb.wr_x] <= lb.wr_code;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_video_if.sv ====
// PROM write bus and line buffer port shared between the engine blocks
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

// one-cycle write strobes from the host, each PROM owner filters on id
interface prom_write_if;
	import sprite_video_pkg::*;

	logic                 we;
	prom_id_e             id;
	logic [`PROM_AW-1:0]  index;
	logic [`WB_DW-1:0]    data;

	modport host    (output we, id, index, data);
	modport blitter (input we, id, index, data);
	modport mixer   (input we, id, index, data);
endinterface

// write side from the blitter, read side from the mixer
interface line_buf_if;
	import sprite_video_pkg::*;

	logic  wr_en;
	x_t    wr_x;
	code_t wr_code;
	logic  rd_en;
	x_t    rd_x;
	code_t rd_code;

	modport blitter (output wr_en, wr_x, wr_code);
	modport mixer   (output rd_en, rd_x, input rd_code);
	modport buffer  (input wr_en, wr_x, wr_code, rd_en, rd_x, output rd_code);
endinterface

`default_nettype wire

// ==== hw/sprite_video_pkg.sv ====
// shared types, host address map and intensity table, imported by the sprite engine RTL
`default_nettype none
`include "sprite_video_settings.svh"

package sprite_video_pkg;

	typedef logic [`CODE_W-1:0] code_t;
	typedef logic [`X_W-1:0] x_t;

	// descriptor color byte
	typedef struct packed {
		logic [2:0] spare;
		logic       flip_x;
		logic       nibble_sel;
		logic [2:0] group;
	} sprite_color_t;

	// host address, seen as descriptor field or PROM location
	typedef struct packed {
		logic [1:0] region;
		logic [2:0] spare;
		logic [2:0] field;
	} wb_desc_addr_t;

	typedef struct packed {
		logic [1:0] region;
		logic       table_sel;
		logic [4:0] index;
	} wb_prom_addr_t;

	typedef union packed {
		wb_desc_addr_t desc;
		wb_prom_addr_t prom;
	} wb_addr_u;

	typedef enum logic [1:0] {color_lut, pal_hi, pal_lo} prom_id_e;

	localparam logic [1:0] region_desc = 2'd0;
	localparam logic [1:0] region_lut  = 2'd1;
	localparam logic [1:0] region_pal  = 2'd2;

	localparam logic [2:0] field_x      = 3'd0;
	localparam logic [2:0] field_color  = 3'd1;
	localparam logic [2:0] field_plane0 = 3'd2;
	localparam logic [2:0] field_plane1 = 3'd3;
	localparam logic [2:0] field_go     = 3'd4;

	// 16 resistor levels shared by all three guns
	localparam logic [7:0] level_table [16] = '{
		8'd0, 8'd0, 8'd0, 8'd88, 8'd0, 8'd112, 8'd133, 8'd192,
		8'd60, 8'd150, 8'd166, 8'd212, 8'd180, 8'd221, 8'd229, 8'd255
	};

endpackage

`default_nettype wire

// ==== hw/sprite_video_settings.svh ====
// width and size macros for the sprite line engine, included by every file that needs them
`ifndef SPRITE_VIDEO_SETTINGS_SVH
`define SPRITE_VIDEO_SETTINGS_SVH

// one video line
`define LINE_PIXELS 256
`define X_W 8

// sprite color code, 0 is transparent
`define CODE_W 4

// color lookup and palette PROMs
`define PROM_DEPTH 32
`define PROM_AW 5

// host bus
`define WB_AW 8
`define WB_DW 8

// pixels per descriptor row, one bit each per plane
`define ROW_PIXELS 8

`endif

// ==== hw/sprite_video_top.sv ====
// top level of the sprite line engine, host bus in and pixel stream out
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_video_top (
	input  logic                 clk_10M,
	input  logic                 RESET,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`WB_AW-1:0]    wb_adr,
	input  logic [`WB_DW-1:0]    wb_dat_w,
	output logic [`WB_DW-1:0]    wb_dat_r,
	output logic                 wb_ack,
	input  logic                 line_start,
	output logic [3*`CODE_W-1:0] rgb,
	output logic                 rgb_valid
);
	import sprite_video_pkg::*;

	prom_write_if prom_bus ();
	line_buf_if   lb_bus ();

	logic                   start;
	logic                   busy;
	logic                   streaming;
	x_t                     sprite_x;
	sprite_color_t          sprite_color;
	logic [`ROW_PIXELS-1:0] plane0;
	logic [`ROW_PIXELS-1:0] plane1;

	sprite_host_port host_port_i (
		.clk_10M      (clk_10M),
		.RESET        (RESET),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.prom         (prom_bus.host),
		.start        (start),
		.sprite_x     (sprite_x),
		.sprite_color (sprite_color),
		.plane0       (plane0),
		.plane1       (plane1),
		.busy         (busy)
	);

	sprite_blitter blitter_i (
		.clk_10M      (clk_10M),
		.RESET        (RESET),
		.prom         (prom_bus.blitter),
		.lb           (lb_bus.blitter),
		.start        (start),
		.sprite_x     (sprite_x),
		.sprite_color (sprite_color),
		.plane0       (plane0),
		.plane1       (plane1),
		.busy         (busy)
	);

	sprite_line_buffer line_buffer_i (
		.clk_10M    (clk_10M),
		.RESET      (RESET),
		.line_start (line_start),
		.streaming  (streaming),
		.lb         (lb_bus.buffer)
	);

	pixel_palette_mixer mixer_i (
		.clk_10M    (clk_10M),
		.RESET      (RESET),
		.line_start (line_start),
		.streaming  (streaming),
		.prom       (prom_bus.mixer),
		.lb         (lb_bus.mixer),
		.rgb        (rgb),
		.rgb_valid  (rgb_valid)
	);

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/sprite_video_pkg.sv
hw/sprite_video_if.sv
hw/sprite_host_port.sv
hw/sprite_blitter.sv
hw/sprite_line_buffer.sv
hw/pixel_palette_mixer.sv
hw/sprite_video_top.sv
tests/sprite_video_checker.sv
tests/sprite_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module sprite_video_tb \
	-o sprite_video_sim \
	&& { ./obj_dir/sprite_video_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& grep -qx "Test OK" sim.log \
	|| { echo "simulation failed"; exit 1; }

// ==== tests/sprite_video_checker.sv ====
// bound assertions on the sprite engine top level, attached to every sprite_video_top by bind
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_video_checker (
	input logic                 clk_10M,
	input logic                 RESET,
	input logic                 wb_cyc,
	input logic                 wb_stb,
	input logic                 wb_ack,
	input logic [3*`CODE_W-1:0] rgb,
	input logic                 rgb_valid,
	input logic                 streaming
);
	int failures = 0;

	// ack answers a request seen on the previous edge
	ack_with_request: assert property (@(posedge clk_10M) disable iff (RESET)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack high without cyc and stb on the previous cycle");
			failures++;
		end

	blank_between_pixels: assert property (@(posedge clk_10M) disable iff (RESET)
		!rgb_valid |-> rgb == '0)
		else begin
			$error("rgb not zero while rgb_valid is low");
			failures++;
		end

	// a pulse inside a line is followed by the next one two cycles later
	pixel_spacing: assert property (@(posedge clk_10M) disable iff (RESET)
		$past(rgb_valid, 2) && $past(streaming, 2) |-> rgb_valid && !$past(rgb_valid))
		else begin
			$error("rgb_valid pulses not two cycles apart");
			failures++;
		end

endmodule

bind sprite_video_top sprite_video_checker checker_i (
	.clk_10M   (clk_10M),
	.RESET     (RESET),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.rgb       (rgb),
	.rgb_valid (rgb_valid),
	.streaming (streaming)
);

`default_nettype wire

// ==== tests/sprite_video_tb.sv ====
// directed testbench for sprite_video_top, built from project.f and run by run_sim.sh
`timescale 1ns/100ps
`default_nettype none
`include "sprite_video_settings.svh"

module sprite_video_tb;

	localparam int line_cycles = 2 * `LINE_PIXELS + 16;
	localparam int blit_cycles = 30;
	// reset and sweep, PROM loads, blits with status polls, seven lines
	localparam int test_cycles = 300 + 3 * `PROM_DEPTH * 2 + 14 * blit_cycles + 7 * line_cycles;

	// video DAC levels for a 4-bit channel index
	localparam logic [7:0] levels [16] = '{
		8'd0, 8'd0, 8'd0, 8'd88, 8'd0, 8'd112, 8'd133, 8'd192,
		8'd60, 8'd150, 8'd166, 8'd212, 8'd180, 8'd221, 8'd229, 8'd255
	};

	logic                    clk_10M;
	logic                    RESET;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [`WB_AW-1:0]       wb_adr;
	logic [`WB_DW-1:0]       wb_dat_w;
	logic [`WB_DW-1:0]       wb_dat_r;
	logic                    wb_ack;
	logic                    line_start;
	logic [3*`CODE_W-1:0]    rgb;
	logic                    rgb_valid;

	int          errors = 0;
	logic [31:0] lfsr_state = 32'h6622;
	logic [7:0]  lut_m [`PROM_DEPTH];
	logic [7:0]  pal_hi_m [`PROM_DEPTH];
	logic [7:0]  pal_lo_m [`PROM_DEPTH];
	// write half of the line buffer as the rules predict it
	logic [3:0]  line_m [`LINE_PIXELS];

	sprite_video_top sprite_video_top_i (
		.clk_10M    (clk_10M),
		.RESET      (RESET),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.line_start (line_start),
		.rgb        (rgb),
		.rgb_valid  (rgb_valid)
	);

	initial begin
		clk_10M = 1'b0;
		forever #50 clk_10M = ~clk_10M;
	end

	initial begin
		#(2 * test_cycles * 100);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [11:0] expected_rgb(input logic [3:0] code);
		logic [7:0] hi;
		logic [7:0] lo;
		if (code == 4'd0) begin
			return 12'h000;
		end
		hi = pal_hi_m[{1'b0, code}];
		lo = pal_lo_m[{1'b0, code}];
		return {levels[{hi[1:0], lo[1:0]}][7:4], levels[{hi[3:2], lo[3:2]}][7:4],
			levels[{hi[5:4], lo[5:4]}][7:4]};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_10M);
		#10;
	endtask

	// one classic cycle, held until ack
	task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [7:0] dat_w,
		output logic [7:0] dat_r, output int cycles);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat_w;
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (!wb_ack && cycles < 100);
		if (!wb_ack) begin
			errors++;
			$display("no Wishbone ack from address %h after %0d cycles", adr, cycles);
		end
		dat_r = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
		logic [7:0] ignored;
		int         cycles;
		wb_cycle(1'b1, adr, dat, ignored, cycles);
	endtask

	task automatic load_proms();
		for (int i = 0; i < `PROM_DEPTH; i++) begin
			lut_m[i] = 8'(random_bits(8));
			pal_hi_m[i] = 8'(random_bits(8));
			pal_lo_m[i] = 8'(random_bits(8));
			wb_write({2'b01, 1'b0, 5'(i)}, lut_m[i]);
			wb_write({2'b10, 1'b0, 5'(i)}, pal_hi_m[i]);
			wb_write({2'b10, 1'b1, 5'(i)}, pal_lo_m[i]);
		end
	endtask

	task automatic model_blit(input logic [7:0] x, input logic [7:0] color,
		input logic [7:0] p0, input logic [7:0] p1);
		logic [7:0] entry;
		logic [1:0] pix;
		int         j;
		for (int i = 0; i < `ROW_PIXELS; i++) begin
			j = color[4] ? `ROW_PIXELS - 1 - i : i;
			pix = {p1[j], p0[j]};
			if (pix != 2'b00) begin
				entry = lut_m[{color[2:0], pix}];
				line_m[8'(int'(x) + i)] = color[3] ? entry[7:4] : entry[3:0];
			end
		end
	endtask

	task automatic blit(input logic [7:0] x, input logic [7:0] color, input logic [7:0] p0,
		input logic [7:0] p1);
		logic [7:0] ignored;
		int         cycles;
		wb_write(8'h00, x);
		wb_write(8'h01, color);
		wb_write(8'h02, p0);
		wb_write(8'h03, p1);
		wb_cycle(1'b1, 8'h04, 8'h00, ignored, cycles);
		model_blit(x, color, p0, p1);
	endtask

	task automatic random_sprite(input logic [7:0] x, input logic flip, input logic nibble,
		input logic [7:0] p0_set);
		logic [7:0] color;
		logic [7:0] p0;
		logic [7:0] p1;
		color = {3'b000, flip, nibble, 3'(random_bits(3))};
		p0 = 8'(random_bits(8)) | p0_set;
		p1 = 8'(random_bits(8));
		blit(x, color, p0, p1);
	endtask

	task automatic wait_idle();
		logic [7:0] status;
		int         cycles;
		int         polls;
		polls = 0;
		do begin
			wb_cycle(1'b0, 8'h04, 8'h00, status, cycles);
			polls++;
		end while (status[0] && polls < 20);
		if (status[0]) begin
			errors++;
			$display("blitter still busy after %0d status reads", polls);
		end
	endtask

	// pulse line_start and compare all 256 pixels against the predicted half
	task automatic run_line();
		logic [3:0] expected [`LINE_PIXELS];
		int         waited;
		int         extra;
		for (int i = 0; i < `LINE_PIXELS; i++) begin
			expected[i] = line_m[i];
			line_m[i] = 4'd0;
		end
		line_start = 1'b1;
		next_cycle();
		line_start = 1'b0;
		waited = 1;
		while (!rgb_valid && waited < 8) begin
			next_cycle();
			waited++;
		end
		compare_value("rgb_valid delay", waited, 3);
		for (int n = 0; n < `LINE_PIXELS; n++) begin
			if (n > 0) begin
				waited = 0;
				do begin
					next_cycle();
					waited++;
				end while (!rgb_valid && waited < 4);
			end
			if (!rgb_valid) begin
				errors++;
				$display("pixel stream stopped before pixel %0d", n);
				return;
			end
			compare_value($sformatf("rgb[%0d]", n), 32'(rgb), 32'(expected_rgb(expected[n])));
		end
		extra = 0;
		repeat (6) begin
			next_cycle();
			if (rgb_valid) begin
				extra++;
			end
		end
		compare_value("rgb_valid after pixel 255", extra, 0);
	endtask

	task automatic registers_after_reset();
		logic [7:0] data;
		logic [7:0] values [4];
		int         cycles;
		values = '{8'h5a, 8'h17, 8'hc3, 8'h3c};
		compare_value("wb_ack", 32'(wb_ack), 0);
		compare_value("rgb_valid", 32'(rgb_valid), 0);
		wb_cycle(1'b0, 8'h04, 8'h00, data, cycles);
		compare_value("status", 32'(data), 0);
		compare_value("wb_ack latency", cycles, 1);
		for (int f = 0; f < 4; f++) begin
			wb_write(8'(f), values[f]);
			wb_cycle(1'b0, 8'(f), 8'h00, data, cycles);
			compare_value($sformatf("wb_dat_r field %0d", f), 32'(data), 32'(values[f]));
		end
	endtask

	task automatic plain_sprite_line();
		load_proms();
		random_sprite(8'd20, 1'b0, 1'b0, 8'h00);
		random_sprite(8'd200, 1'b0, 1'b0, 8'h81);
		wait_idle();
		run_line();
	endtask

	task automatic flip_and_nibble_line();
		random_sprite(8'd100, 1'b1, 1'b0, 8'h00);
		random_sprite(8'd140, 1'b0, 1'b1, 8'h00);
		// flipped, so bits 3..0 land on positions 0..3 after the wrap
		random_sprite(8'd252, 1'b1, 1'b1, 8'h0f);
		wait_idle();
		run_line();
	endtask

	task automatic overlapping_sprites();
		blit(8'd60, 8'h02, 8'hff, 8'hff);
		blit(8'd63, 8'h0d, 8'b0110_1001, 8'b0101_0011);
		wait_idle();
		run_line();
	endtask

	task automatic double_buffering();
		random_sprite(8'd30, 1'b0, 1'b0, 8'hff);
		wait_idle();
		fork
			run_line();
			begin
				repeat (20) next_cycle();
				random_sprite(8'd80, 1'b1, 1'b0, 8'hff);
				wait_idle();
			end
		join
		run_line();
		// nothing written since, the streamed half must come back empty
		run_line();
	endtask

	task automatic go_back_pressure();
		logic [7:0] x;
		logic [7:0] ignored;
		int         cycles;
		blit(8'd10, 8'h05, 8'hb7, 8'h6e);
		for (int k = 1; k < 4; k++) begin
			x = 8'(10 + 40 * k);
			wb_write(8'h00, x);
			wb_cycle(1'b1, 8'h04, 8'h00, ignored, cycles);
			if (cycles <= 2) begin
				errors++;
				$display("go write for x %0d was acked while the blitter was busy", x);
			end
			model_blit(x, 8'h05, 8'hb7, 8'h6e);
		end
		wait_idle();
		run_line();
	endtask

	initial begin
		RESET = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		line_start = 1'b0;
		for (int i = 0; i < `LINE_PIXELS; i++) begin
			line_m[i] = 4'd0;
		end
		repeat (5) @(posedge clk_10M);
		#10;
		RESET = 1'b0;
		registers_after_reset();
		// line buffer clears itself after reset
		repeat (`LINE_PIXELS + 4) next_cycle();
		plain_sprite_line();
		flip_and_nibble_line();
		overlapping_sprites();
		double_buffering();
		go_back_pressure();
		$display("failed checks: %0d, failed assertions: %0d", errors,
			sprite_video_top_i.checker_i.failures);
		if (errors == 0 && sprite_video_top_i.checker_i.failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
